/* design/pager_pkg.sv */
package pager_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and page geometry
	////////////////////////////////////////////////////////////////////////////

	// cpu address width
	localparam int addr_w = 16;

	// page number width
	localparam int page_w = 8;

	// offset inside one 16k window
	localparam int ofs_w = 14;

	// physical address is page then offset
	localparam int phys_w = page_w + ofs_w;

	// four 16k windows cover the cpu space
	localparam int win_count = 4;

	////////////////////////////////////////////////////////////////////////////
	// io ports
	////////////////////////////////////////////////////////////////////////////

	// fully decoded pentagon paging port
	localparam logic [addr_w-1:0] port_pent = 16'h7FFD;

	// low bytes of the atm ports, high bits pick the window
	localparam logic [7:0] port_atm_lo = 8'hF7;
	localparam logic [7:0] port_pen_lo = 8'h77;

	// fixed pentagon ram pages in windows 1 and 2
	localparam logic [page_w-1:0] pent_win1_page = 8'd5;
	localparam logic [page_w-1:0] pent_win2_page = 8'd2;

	// high address byte of the trdos entry area
	localparam logic [7:0] dos_lo_hi = 8'h3D;

	// kind of a decoded port write
	typedef enum logic [1:0]
	{
		op_none,
		op_pent,
		op_atm_page,
		op_pen
	} port_op_e;

endpackage

/* design/pager_ports.sv */
module pager_ports
	import pager_pkg::*;
#(
	parameter int ADDR_W    = addr_w,
	parameter int WIN_COUNT = win_count
)
(
	input  logic                 fclk,
	input  logic                 rst_n,

	input  logic                 io_wr,
	input  logic [ADDR_W-1:0]    io_addr,
	input  logic [7:0]           io_data,

	output logic [WIN_COUNT-1:0] page_we,
	output logic [7:0]           page_data,

	output logic [2:0]           pent_page,
	output logic                 pent_rom,
	output logic                 pager_off
);

	localparam int WSEL_W = $clog2(WIN_COUNT);

	port_op_e          op;
	logic [WSEL_W-1:0] win_sel;

	////////////////////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		op = op_none;
		if (io_wr)
		begin
			// 7ffd needs all 16 bits, atm ports only the low byte
			if (io_addr == port_pent)
				op = op_pent;
			else if (io_addr[7:0] == port_atm_lo)
				op = op_atm_page;
			else if (io_addr[7:0] == port_pen_lo)
				op = op_pen;
		end
	end

	// top address bits name the window
	assign win_sel = io_addr[ADDR_W-1 -: WSEL_W];

	// one enable per window, at most one set
	always_comb
	begin
		for (int w = 0; w < WIN_COUNT; w++)
			page_we[w] = (op == op_atm_page) && (win_sel == WSEL_W'(w));
	end

	assign page_data = io_data;

	////////////////////////////////////////////////////////////////////////////
	// pentagon and pager enable registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pent_page <= 3'd0;
			pent_rom  <= 1'b0;
			// start in pentagon mode
			pager_off <= 1'b1;
		end
		else
		begin
			case (op)
				op_pent:
				begin
					pent_page <= io_data[2:0];
					pent_rom  <= io_data[4];
				end
				op_pen:
				begin
					// bit 0 set turns the atm pagers on
					pager_off <= ~io_data[0];
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

/* design/atm_pager.sv */
module atm_pager
	import pager_pkg::*;
#(
	parameter int WIN    = 0,
	parameter int PAGE_W = page_w
)
(
	input  logic              fclk,
	input  logic              rst_n,

	input  logic              page_we,
	input  logic [7:0]        page_data,

	input  logic [2:0]        pent_page,
	input  logic              pent_rom,
	input  logic              pager_off,
	input  logic              dos,

	// address bits 13:8 and fetch flag of the current access
	input  logic [5:0]        mem_hi,
	input  logic              mem_m1,

	output logic [PAGE_W-1:0] page,
	output logic              romnram,
	output logic              dos_turn_on,
	output logic              dos_turn_off
);

	logic [5:0] atm_page;
	logic       atm_ram;

	////////////////////////////////////////////////////////////////////////////
	// atm page register for this window
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// rom page 0 after reset
			atm_page <= 6'd0;
			atm_ram  <= 1'b0;
		end
		else if (page_we)
		begin
			atm_page <= page_data[5:0];
			atm_ram  <= page_data[6];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// mapping
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (pager_off)
		begin
			// classic pentagon layout, fixed by window index
			case (WIN)
				0:
				begin
					romnram = 1'b1;
					// bit 1 low selects the trdos rom
					page    = PAGE_W'({~dos, pent_rom});
				end
				1:
				begin
					romnram = 1'b0;
					page    = PAGE_W'(pent_win1_page);
				end
				2:
				begin
					romnram = 1'b0;
					page    = PAGE_W'(pent_win2_page);
				end
				default:
				begin
					romnram = 1'b0;
					page    = PAGE_W'(pent_page);
				end
			endcase
		end
		else
		begin
			romnram = ~atm_ram;
			page    = PAGE_W'(atm_page);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// dos triggers
	////////////////////////////////////////////////////////////////////////////

	// entry into 3dxx of the basic rom, window 0 only
	assign dos_turn_on = (WIN == 0) && mem_m1 && romnram && pent_rom &&
		({2'b00, mem_hi} == dos_lo_hi);

	// any opcode fetch from ram leaves dos
	assign dos_turn_off = mem_m1 && !romnram;

endmodule

/* design/zmem_map.sv */
module zmem_map
	import pager_pkg::*;
#(
	parameter int ADDR_W    = addr_w,
	parameter int PAGE_W    = page_w,
	parameter int WIN_COUNT = win_count
)
(
	input  logic                                fclk,
	input  logic                                rst_n,

	input  logic                                mem_req,
	input  logic [ADDR_W-1:0]                   mem_addr,

	input  logic [WIN_COUNT-1:0][PAGE_W-1:0]    win_page,
	input  logic [WIN_COUNT-1:0]                win_romnram,
	input  logic [WIN_COUNT-1:0]                win_dos_on,
	input  logic [WIN_COUNT-1:0]                win_dos_off,

	output logic                                dos,

	output logic                                map_valid,
	output logic                                map_rom,
	output logic [PAGE_W-1:0]                   map_page,
	output logic [PAGE_W+ofs_w-1:0]             phys_addr
);

	localparam int WSEL_W = $clog2(WIN_COUNT);

	logic [WSEL_W-1:0] sel;

	// window addressed by the request
	assign sel = mem_addr[ADDR_W-1 -: WSEL_W];

	////////////////////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			map_valid <= 1'b0;
			dos       <= 1'b0;
		end
		else
		begin
			map_valid <= mem_req;
			// the request itself was mapped with the old dos
			if (mem_req && win_dos_on[sel])
				dos <= 1'b1;
			else if (mem_req && win_dos_off[sel])
				dos <= 1'b0;
		end
	end

	// mapped result, one cycle after the request
	always_ff @(posedge fclk)
	begin
		if (mem_req)
		begin
			map_rom   <= win_romnram[sel];
			map_page  <= win_page[sel];
			phys_addr <= {win_page[sel], mem_addr[ofs_w-1:0]};
		end
	end

endmodule

/* design/zpaging.sv */
module zpaging
	import pager_pkg::*;
#(
	parameter int ADDR_W    = addr_w,
	parameter int PAGE_W    = page_w,
	parameter int WIN_COUNT = win_count
)
(
	input  logic                    fclk,
	input  logic                    rst_n,

	// port writes
	input  logic                    io_wr,
	input  logic [ADDR_W-1:0]       io_addr,
	input  logic [7:0]              io_data,

	// memory accesses
	input  logic                    mem_req,
	input  logic [ADDR_W-1:0]       mem_addr,
	input  logic                    mem_m1,

	output logic                    map_valid,
	output logic                    map_rom,
	output logic [PAGE_W-1:0]       map_page,
	output logic [PAGE_W+ofs_w-1:0] phys_addr
);

	logic [WIN_COUNT-1:0]             page_we;
	logic [7:0]                       page_data;
	logic [2:0]                       pent_page;
	logic                             pent_rom;
	logic                             pager_off;
	logic                             dos;

	logic [WIN_COUNT-1:0][PAGE_W-1:0] win_page;
	logic [WIN_COUNT-1:0]             win_romnram;
	logic [WIN_COUNT-1:0]             win_dos_on;
	logic [WIN_COUNT-1:0]             win_dos_off;

	////////////////////////////////////////////////////////////////////////////
	// port decoder
	////////////////////////////////////////////////////////////////////////////

	pager_ports #(
		.ADDR_W   (ADDR_W),
		.WIN_COUNT(WIN_COUNT)
	) ports_i (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.io_wr    (io_wr),
		.io_addr  (io_addr),
		.io_data  (io_data),
		.page_we  (page_we),
		.page_data(page_data),
		.pent_page(pent_page),
		.pent_rom (pent_rom),
		.pager_off(pager_off)
	);

	////////////////////////////////////////////////////////////////////////////
	// one pager per window
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < WIN_COUNT; i++)
	begin : gen_pagers
		atm_pager #(
			.WIN   (i),
			.PAGE_W(PAGE_W)
		) pager_i (
			.fclk        (fclk),
			.rst_n       (rst_n),
			.page_we     (page_we[i]),
			.page_data   (page_data),
			.pent_page   (pent_page),
			.pent_rom    (pent_rom),
			.pager_off   (pager_off),
			.dos         (dos),
			.mem_hi      (mem_addr[13:8]),
			.mem_m1      (mem_m1),
			.page        (win_page[i]),
			.romnram     (win_romnram[i]),
			.dos_turn_on (win_dos_on[i]),
			.dos_turn_off(win_dos_off[i])
		);
	end

	// window select, result register and dos flag
	zmem_map #(
		.ADDR_W   (ADDR_W),
		.PAGE_W   (PAGE_W),
		.WIN_COUNT(WIN_COUNT)
	) map_i (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.win_page   (win_page),
		.win_romnram(win_romnram),
		.win_dos_on (win_dos_on),
		.win_dos_off(win_dos_off),
		.dos        (dos),
		.map_valid  (map_valid),
		.map_rom    (map_rom),
		.map_page   (map_page),
		.phys_addr  (phys_addr)
	);

endmodule

/* bench/zpaging_stim.svh */
`ifndef ZPAGING_STIM_SVH
`define ZPAGING_STIM_SVH

logic [31:0] rng_state = 32'd12;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function logic [31:0] next_rand();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

// one clock of inputs, applied right after the rising edge
task drive_cycle(input logic iw, input logic [15:0] ia, input logic [7:0] id,
	input logic mr, input logic [15:0] ma, input logic m1);
	@(posedge fclk);
	io_wr    <= iw;
	io_addr  <= ia;
	io_data  <= id;
	mem_req  <= mr;
	mem_addr <= ma;
	mem_m1   <= m1;
endtask

task idle_cycles(input int n);
	repeat (n)
		drive_cycle(1'b0, 16'h0000, 8'h00, 1'b0, 16'h0000, 1'b0);
endtask

task io_write(input logic [15:0] addr, input logic [7:0] data);
	drive_cycle(1'b1, addr, data, 1'b0, 16'h0000, 1'b0);
endtask

task mem_access(input logic [15:0] addr, input logic m1);
	drive_cycle(1'b0, 16'h0000, 8'h00, 1'b1, addr, m1);
endtask

// port write and access in the same cycle, then the access again
task write_and_access(input logic [15:0] wa, input logic [7:0] wd, input logic [15:0] ma);
	drive_cycle(1'b1, wa, wd, 1'b1, ma, 1'b0);
	mem_access(ma, 1'b0);
endtask

// one plain read per window at random offsets
task touch_windows();
	logic [31:0] r;
	for (int w = 0; w < 4; w++)
	begin
		r = next_rand();
		mem_access({w[1:0], r[13:0]}, 1'b0);
	end
endtask

`endif

/* bench/zpaging_tb.sv */
module zpaging_tb;

	localparam int clk_period = 8;
	localparam int n_pent     = 32;
	localparam int n_atm      = 48;
	localparam int n_b2b      = 200;
	localparam int stim_cycles = 40 + 3 * n_pent + 5 * n_atm + n_b2b;

	logic        fclk;
	logic        rst_n;
	logic        io_wr;
	logic [15:0] io_addr;
	logic [7:0]  io_data;
	logic        mem_req;
	logic [15:0] mem_addr;
	logic        mem_m1;
	logic        map_valid;
	logic        map_rom;
	logic [7:0]  map_page;
	logic [21:0] phys_addr;

	int mismatch_count = 0;
	int other_count    = 0;
	int req_count      = 0;
	int valid_count    = 0;

	`include "zpaging_stim.svh"

	initial
	begin
		fclk = 1'b0;
		forever #(clk_period / 2) fclk = ~fclk;
	end

	zpaging #(
		.ADDR_W   (16),
		.PAGE_W   (8),
		.WIN_COUNT(4)
	) dut_i (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.io_wr    (io_wr),
		.io_addr  (io_addr),
		.io_data  (io_data),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_m1   (mem_m1),
		.map_valid(map_valid),
		.map_rom  (map_rom),
		.map_page (map_page),
		.phys_addr(phys_addr)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	logic [2:0]  m_pent_page;
	logic        m_pent_rom;
	logic        m_pager_off;
	logic        m_dos;
	logic [5:0]  m_atm_page [4];
	logic        m_atm_ram [4];
	logic [8:0]  m_res;
	logic        exp_valid;
	logic        exp_rom;
	logic [7:0]  exp_page;
	logic [21:0] exp_phys;

	// rom flag in bit 8 and the page below it
	function automatic logic [8:0] model_map(input logic [15:0] a);
		logic [1:0] w;
		logic [8:0] r;
		w = a[15:14];
		if (m_pager_off)
		begin
			case (w)
				2'd0: r = {1'b1, 6'd0, ~m_dos, m_pent_rom};
				2'd1: r = {1'b0, 8'd5};
				2'd2: r = {1'b0, 8'd2};
				default: r = {1'b0, 5'd0, m_pent_page};
			endcase
		end
		else
			r = {~m_atm_ram[w], 2'b00, m_atm_page[w]};
		return r;
	endfunction

	always @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			m_pent_page <= 3'd0;
			m_pent_rom  <= 1'b0;
			m_pager_off <= 1'b1;
			m_dos       <= 1'b0;
			exp_valid   <= 1'b0;
			for (int w = 0; w < 4; w++)
			begin
				m_atm_page[w] <= 6'd0;
				m_atm_ram[w]  <= 1'b0;
			end
		end
		else
		begin
			exp_valid <= mem_req;
			if (mem_req)
			begin
				req_count = req_count + 1;
				// mapped with the state from before this edge
				m_res = model_map(mem_addr);
				exp_rom  <= m_res[8];
				exp_page <= m_res[7:0];
				exp_phys <= {m_res[7:0], mem_addr[13:0]};
				if (mem_m1 && m_res[8] && m_pent_rom && mem_addr[15:8] == 8'h3D)
					m_dos <= 1'b1;
				else if (mem_m1 && !m_res[8])
					m_dos <= 1'b0;
			end
			if (io_wr)
			begin
				if (io_addr == 16'h7FFD)
				begin
					m_pent_page <= io_data[2:0];
					m_pent_rom  <= io_data[4];
				end
				else if (io_addr[7:0] == 8'hF7)
				begin
					m_atm_page[io_addr[15:14]] <= io_data[5:0];
					m_atm_ram[io_addr[15:14]]  <= io_data[6];
				end
				else if (io_addr[7:0] == 8'h77)
					m_pager_off <= ~io_data[0];
			end
		end
	end

	always @(posedge fclk)
	begin
		if (rst_n && map_valid)
			valid_count = valid_count + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	valid_chk: assert property (@(posedge fclk) disable iff (!rst_n) map_valid == exp_valid)
	else
	begin
		mismatch_count = mismatch_count + 1;
		$display("MISMATCH t=%0t map_valid dut=%0b exp=%0b", $time,
			$sampled(map_valid), $sampled(exp_valid));
	end

	rom_chk: assert property (@(posedge fclk) disable iff (!rst_n)
		map_valid |-> map_rom == exp_rom)
	else
	begin
		mismatch_count = mismatch_count + 1;
		$display("MISMATCH t=%0t map_rom dut=%0b exp=%0b", $time,
			$sampled(map_rom), $sampled(exp_rom));
	end

	page_chk: assert property (@(posedge fclk) disable iff (!rst_n)
		map_valid |-> map_page == exp_page)
	else
	begin
		mismatch_count = mismatch_count + 1;
		$display("MISMATCH t=%0t map_page dut=%h exp=%h", $time,
			$sampled(map_page), $sampled(exp_page));
	end

	phys_chk: assert property (@(posedge fclk) disable iff (!rst_n)
		map_valid |-> phys_addr == exp_phys)
	else
	begin
		mismatch_count = mismatch_count + 1;
		$display("MISMATCH t=%0t phys_addr dut=%h exp=%h", $time,
			$sampled(phys_addr), $sampled(exp_phys));
	end

	// twice the stimulus length plus some slack
	initial
	begin
		#((2 * stim_cycles + 200) * clk_period);
		$display("watchdog expired before the stimulus finished");
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		rst_n    = 1'b0;
		io_wr    = 1'b0;
		io_addr  = 16'h0000;
		io_data  = 8'h00;
		mem_req  = 1'b0;
		mem_addr = 16'h0000;
		mem_m1   = 1'b0;
		repeat (4) @(posedge fclk);
		rst_n <= 1'b1;

		// quiet bus and then the reset layout
		idle_cycles(3);
		touch_windows();
		idle_cycles(2);

		// pentagon port with the old mapping in the write cycle
		for (int i = 0; i < n_pent; i++)
		begin
			r = next_rand();
			write_and_access(16'h7FFD, r[7:0], {2'b11, r[21:8]});
			mem_access({2'b00, r[29:16]}, 1'b0);
		end

		// atm mode on with per window pages and back off
		io_write(16'h0077, 8'h01);
		for (int i = 0; i < n_atm; i++)
		begin
			r = next_rand();
			io_write({r[1:0], 6'h00, 8'hF7}, r[15:8]);
			touch_windows();
		end
		io_write(16'h0077, 8'h00);
		touch_windows();

		// dos entry and exit
		io_write(16'h7FFD, 8'h10);
		mem_access(16'h3D2F, 1'b0);
		mem_access(16'h0000, 1'b0);
		mem_access(16'h3D00, 1'b1);
		mem_access(16'h0100, 1'b0);
		mem_access(16'h8000, 1'b1);
		mem_access(16'h0000, 1'b0);
		idle_cycles(2);

		// request in every cycle
		for (int i = 0; i < n_b2b; i++)
		begin
			r = next_rand();
			mem_access(r[15:0], r[16] & r[17]);
		end
		idle_cycles(4);

		if (valid_count != req_count)
		begin
			other_count = other_count + 1;
			$display("%0d requests were sent but %0d results came back",
				req_count, valid_count);
		end
		$display("mismatches %0d, other errors %0d", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* list.f */
+incdir+bench
design/pager_pkg.sv
design/pager_ports.sv
design/atm_pager.sv
design/zmem_map.sv
design/zpaging.sv
bench/zpaging_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert
LFLAGS   := --lint-only --timing --assert
TOP      := zpaging_tb
FILELIST := list.f
OBJDIR   := obj_dir
PASS_MSG := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)
